//--- ssm_block.f
verilog/ssm_num_pkg.sv
verilog/ssm_stage_pkg.sv
verilog/ssm_tile_decode.sv
verilog/ssm_state_update.sv
verilog/ssm_group_result.sv
verilog/ssm_block.sv
bench/ssm_block_checker.sv
bench/ssm_block_tb.sv

//--- verilog/decay_lut.mem
// one q8.8 hex word per line, line i holds round(256 * exp(-i/8)), index 0 first
0100
00E2
00C7
00B0
009B
0089
0079
006B
005E
0053
0049
0041
0039
0032
002C
0027
0023
001F
001B
0018
0015
0013
0010
000E
000D
000B
000A
0009
0008
0007
0006
0005

//--- bench/ssm_block_tb.sv
// ten groups of four tiles, inputs change 1 ns after the rising edge, y_ready_i stalls 7 of every 20 cycles
`timescale 1ns/1ns

module ssm_block_tb;
    import ssm_num_pkg::*;
    import ssm_stage_pkg::*;

    logic         clk;
    logic         rstn;
    logic         tile_valid;
    logic         tile_ready;
    tile_in_t     tile;
    data_t        y;
    logic         y_valid;
    logic         y_ready;
    tile_in_t     tiles [10][TILES_PER_GROUP];   // stimulus table, one row per group
    logic [127:0] names [10];
    logic [127:0] cur_name;                      // name of the group on the bus
    int           seed;
    int           cyc_cnt;
    int           n_groups;
    int           timeout_cyc;
    int           pass_cnt;
    int           fail_cnt;
    int           seen_cnt;

    always #10 clk = ~clk;                       // 20 ns period

    ssm_block i_ssm_block (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid),
        .tile_ready_o (tile_ready),
        .tile_i       (tile),
        .y_o          (y),
        .y_valid_o    (y_valid),
        .y_ready_i    (y_ready)
    );

    ssm_block_checker i_checker (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid),
        .tile_ready_i (tile_ready),
        .tile_i       (tile),
        .name_i       (cur_name),
        .y_i          (y),
        .y_valid_i    (y_valid),
        .y_ready_i    (y_ready),
        .pass_cnt_o   (pass_cnt),
        .fail_cnt_o   (fail_cnt),
        .seen_cnt_o   (seen_cnt)
    );

    // ========================================================================
    // stimulus table
    // ========================================================================

    // lane values follow a small pattern so hand checks stay easy
    task automatic set_group(input int g, input logic [127:0] name, input data_t dt,
                             input data_t bias, input data_t a, input data_t x,
                             input data_t d);
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            tiles[g][t].dt      = dt;
            tiles[g][t].dt_bias = bias;
            tiles[g][t].a       = a;
            tiles[g][t].x       = x;
            tiles[g][t].d       = d;
            for (int n = 0; n < N_TILE; n++) begin
                tiles[g][t].b[n]     = data_t'(16'h0040 + 16 * (t * N_TILE + n));
                tiles[g][t].c[n]     = data_t'(16'h0100 - 8 * (t * N_TILE + n));
                tiles[g][t].hprev[n] = data_t'(16'h0030 * (n + 1) - 16'h0020 * t);
            end
        end
        names[g] = name;
    endtask

    // full range lanes for wraparound, dt and a kept small so delta*|a| < 64
    task automatic set_random_group(input int g, input logic [127:0] name);
        data_t x;
        data_t d;
        x = data_t'($random(seed));
        d = data_t'($random(seed));
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            tiles[g][t].dt      = data_t'($random(seed) % 1024);   // within (-4, 4)
            tiles[g][t].dt_bias = data_t'($random(seed) % 1024);
            tiles[g][t].a       = data_t'($random(seed) % 2048);   // within (-8, 8)
            tiles[g][t].x       = x;                               // constant over the group
            tiles[g][t].d       = d;
            for (int n = 0; n < N_TILE; n++) begin
                tiles[g][t].b[n]     = data_t'($random(seed));
                tiles[g][t].c[n]     = data_t'($random(seed));
                tiles[g][t].hprev[n] = data_t'($random(seed));
            end
        end
        names[g] = name;
    endtask

    task automatic build_table();
        set_group(0, "a_zero",   16'h0080, 16'h0040, 16'h0000, 16'h0100, 16'h0080); // index 0
        set_group(1, "a_half",   16'h0080, 16'h0040, 16'hFF80, 16'h0100, 16'h0080); // index 3
        set_group(2, "a_two",    16'h0080, 16'h0040, 16'hFE00, 16'h00C0, 16'hFF40); // index 12
        set_group(3, "a_four",   16'h0080, 16'h0040, 16'hFC00, 16'h0180, 16'h0040); // index 24
        set_group(4, "a_sat",    16'h0200, 16'h0040, 16'hF800, 16'h0100, 16'h0100); // saturates
        set_group(5, "dt_clamp", 16'hFF00, 16'h0040, 16'hFF00, 16'h0200, 16'h0080); // delta 0
        set_random_group(6, "rand_a");
        set_random_group(7, "rand_b");
        set_random_group(8, "rand_c");
        set_random_group(9, "rand_d");
    endtask

    // ========================================================================
    // drive, ready pattern and timeout
    // ========================================================================

    // hold the tile until an edge sees tile_ready_o high
    task automatic drive_tile(input tile_in_t t, input logic [127:0] name);
        tile_valid = 1'b1;
        tile       = t;
        cur_name   = name;
        @(posedge clk);
        while (!tile_ready)
            @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        y_ready = (cyc_cnt % 20) < 13;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt == timeout_cyc) begin
            $display("timeout after %0d cycles, only %0d of %0d group results arrived",
                     cyc_cnt, seen_cnt, n_groups);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 11131;
        clk         = 1'b0;
        rstn        = 1'b0;
        tile_valid  = 1'b0;
        tile        = '0;
        y_ready     = 1'b1;
        cur_name    = '0;
        cyc_cnt     = 0;
        n_groups    = $size(names);
        timeout_cyc = n_groups * (TILES_PER_GROUP + 5) * 4 + 50;
        build_table();
        repeat (2) @(posedge clk);               // reset held for two cycles
        #1 rstn = 1'b1;
        @(posedge clk);
        #1;
        for (int g = 0; g < n_groups; g++) begin
            for (int t = 0; t < TILES_PER_GROUP; t++) begin
                drive_tile(tiles[g][t], names[g]);
            end
        end
        tile_valid = 1'b0;
        wait (seen_cnt >= n_groups);
        repeat (10) @(posedge clk);              // room for a stray extra result
        $display("groups %0d, results %0d, passed %0d, failed %0d", n_groups, seen_cnt,
                 pass_cnt, fail_cnt);
        if (fail_cnt == 0 && seen_cnt == n_groups && pass_cnt == n_groups + 1)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- bench/ssm_block_checker.sv
// expects delta*|a| below 64 for every tile and x and d constant within a group
`timescale 1ns/1ns

module ssm_block_checker (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    tile_valid_i,
    input  logic                    tile_ready_i,
    input  ssm_stage_pkg::tile_in_t tile_i,
    input  logic [127:0]            name_i,      // group name as ascii
    input  ssm_num_pkg::data_t      y_i,
    input  logic                    y_valid_i,
    input  logic                    y_ready_i,
    output int                      pass_cnt_o,
    output int                      fail_cnt_o,
    output int                      seen_cnt_o   // results taken so far
);
    import ssm_num_pkg::*;
    import ssm_stage_pkg::*;

    data_t        decay_tab [LUT_DEPTH];         // exp(-i/8) in q8.8, rounded
    data_t        exp_q [$];                     // expected y per group in input order
    logic [127:0] name_q [$];
    logic [127:0] in_name;                       // name of the group being fed
    logic [127:0] out_name;
    data_t        acc;                           // model group sum
    data_t        xd;
    data_t        exp_y;
    data_t        y_hold;                        // y seen on the last stalled edge
    logic         stalled;
    int           tile_pos;

    initial begin
        for (int i = 0; i < LUT_DEPTH; i++) begin
            decay_tab[i] = data_t'($rtoi($itor(1 << FRAC_BITS) * $exp(-i / 8.0) + 0.5));
        end
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        seen_cnt_o = 0;
        tile_pos   = 0;
        stalled    = 1'b0;
    end

    // ========================================================================
    // reference model
    // ========================================================================

    // keeps bits 23..8 of the full 32 bit product
    function automatic data_t ref_mul(input data_t a, input data_t b);
        logic signed [31:0] full;
        full = 32'(a) * 32'(b);
        return full[FRAC_BITS +: 16];
    endfunction

    // sum of h_next * c over the lanes of one tile
    function automatic data_t tile_sum(input tile_in_t t);
        data_t delta;
        data_t mag;
        data_t prod;
        data_t da;
        data_t hn;
        data_t s;
        int    idx;
        delta = t.dt + t.dt_bias;
        if (delta < 0)
            delta = '0;                          // negative step clamps to zero
        mag  = (t.a < 0) ? -t.a : '0;
        prod = ref_mul(delta, mag);              // never negative for the bench ranges
        idx  = prod >>> LUT_SHIFT;
        if (idx > LUT_DEPTH - 1)
            idx = LUT_DEPTH - 1;
        da = decay_tab[idx];
        s  = '0;
        for (int n = 0; n < N_TILE; n++) begin
            hn = ref_mul(da, t.hprev[n]) + ref_mul(ref_mul(delta, t.x), t.b[n]);
            s  = s + ref_mul(hn, t.c[n]);        // wraps
        end
        return s;
    endfunction

    // ========================================================================
    // reset state before the first tile
    // ========================================================================
    initial begin
        @(posedge rstn);
        @(negedge clk);
        if (y_valid_i !== 1'b0 || tile_ready_i !== 1'b1) begin
            $display("after reset y_valid_o is %b and tile_ready_o is %b", y_valid_i,
                     tile_ready_i);
            fail_cnt_o++;
        end else begin
            $display("pass reset_state");
            pass_cnt_o++;
        end
    end

    // ========================================================================
    // handshake monitor
    // ========================================================================
    always @(posedge clk) begin
        if (rstn) begin
            if (stalled && (!y_valid_i || y_i !== y_hold)) begin
                $display("y_o or y_valid_o changed while the result was not taken");
                fail_cnt_o++;
            end
            if (y_valid_i && !y_ready_i && tile_ready_i) begin
                $display("tile_ready_o high while a result waits");
                fail_cnt_o++;
            end
            stalled = y_valid_i && !y_ready_i;
            y_hold  = y_i;

            if (tile_valid_i && tile_ready_i) begin
                if (tile_pos == 0) begin
                    acc     = '0;
                    xd      = ref_mul(tile_i.x, tile_i.d);   // x and d from the first tile
                    in_name = name_i;
                end
                acc = acc + tile_sum(tile_i);
                if (tile_pos == TILES_PER_GROUP - 1) begin
                    exp_q.push_back(acc + xd);
                    name_q.push_back(in_name);
                    tile_pos = 0;
                end else begin
                    tile_pos++;
                end
            end

            if (y_valid_i && y_ready_i) begin
                seen_cnt_o++;
                if (exp_q.size() == 0) begin
                    $display("result %h arrived with no group outstanding", y_i);
                    fail_cnt_o++;
                end else begin
                    exp_y    = exp_q.pop_front();
                    out_name = name_q.pop_front();
                    if (y_i !== exp_y) begin
                        $display("error %0s expected %h actual %h", out_name, exp_y, y_i);
                        fail_cnt_o++;
                    end else begin
                        $display("pass %0s y %h", out_name, y_i);
                        pass_cnt_o++;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/ssm_block.sv
// selective scan block top, back-pressure on y stalls every stage, so tile_ready_o drops while a result waits
`timescale 1ns/1ns

module ssm_block (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    tile_valid_i,
    output logic                    tile_ready_o,
    input  ssm_stage_pkg::tile_in_t tile_i,
    output ssm_num_pkg::data_t      y_o,
    output logic                    y_valid_o,
    input  logic                    y_ready_i
);
    import ssm_stage_pkg::*;

    logic         adv;                           // global stage enable
    logic         dec_valid;
    decoded_t     dec;
    logic         res_valid;
    lane_result_t res;

    // ========================================================================
    // stall control
    // ========================================================================
    assign adv          = ~(y_valid_o & ~y_ready_i); // freeze while y is unread
    assign tile_ready_o = adv;

    // ========================================================================
    // pipeline
    // ========================================================================
    ssm_tile_decode i_decode (
        .clk     (clk),
        .rstn    (rstn),
        .adv_i   (adv),
        .valid_i (tile_valid_i),
        .tile_i  (tile_i),
        .valid_o (dec_valid),
        .dec_o   (dec)
    );

    ssm_state_update i_update (
        .clk     (clk),
        .rstn    (rstn),
        .adv_i   (adv),
        .valid_i (dec_valid),
        .dec_i   (dec),
        .valid_o (res_valid),
        .res_o   (res)
    );

    ssm_group_result i_result (
        .clk       (clk),
        .rstn      (rstn),
        .adv_i     (adv),
        .valid_i   (res_valid),
        .res_i     (res),
        .y_o       (y_o),
        .y_valid_o (y_valid_o)
    );

endmodule

//--- verilog/ssm_group_result.sv
// group sum plus x*d from the first tile, one result held until taken since nothing moves while it waits
`timescale 1ns/1ns

module ssm_group_result (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        adv_i,
    input  logic                        valid_i,
    input  ssm_stage_pkg::lane_result_t res_i,
    output ssm_num_pkg::data_t          y_o,
    output logic                        y_valid_o
);
    import ssm_num_pkg::*;

    data_t tile_sum;                             // sum of this tile's lanes
    data_t acc_base;                             // accumulator before this tile
    data_t grp_total;                            // accumulator after this tile
    data_t xd_sel;
    data_t acc_q;                                // running group sum
    data_t xd_q;                                 // x*d held from the first tile
    logic  take;

    // ========================================================================
    // lane and tile summation
    // ========================================================================
    always_comb begin
        tile_sum = '0;
        for (int n = 0; n < N_TILE; n++) begin
            tile_sum = tile_sum + res_i.hc[n];   // wraps like every add
        end
    end

    assign acc_base  = res_i.first ? '0 : acc_q; // restart on a new group
    assign grp_total = acc_base + tile_sum;
    assign xd_sel    = res_i.first ? res_i.xd : xd_q;
    assign take      = adv_i & valid_i;

    always_ff @(posedge clk) begin
        if (take) begin
            acc_q <= grp_total;
            if (res_i.first)
                xd_q <= res_i.xd;
            if (res_i.last)
                y_o <= grp_total + xd_sel;       // y stays put until the next last tile
        end
    end

    // ========================================================================
    // output valid
    // ========================================================================

    // adv high means the old result was taken or never there
    // so the flag just follows a new last tile
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            y_valid_o <= 1'b0;
        end else if (adv_i) begin
            y_valid_o <= valid_i & res_i.last;
        end
    end

endmodule

//--- verilog/ssm_state_update.sv
// three stage q8.8 state update, decay comes from a 32 entry table loaded once at start-up and never written
`timescale 1ns/1ns

module ssm_state_update (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        adv_i,
    input  logic                        valid_i,
    input  ssm_stage_pkg::decoded_t     dec_i,
    output logic                        valid_o,
    output ssm_stage_pkg::lane_result_t res_o
);
    import ssm_num_pkg::*;

    // stage one result
    typedef struct packed {
        lut_idx_t  idx;                          // decay table address
        data_t     dx;                           // delta * x
        lane_vec_t b;
        lane_vec_t c;
        lane_vec_t hprev;
        data_t     x;
        data_t     d;
        logic      first;
        logic      last;
    } s1_t;

    // stage two result
    typedef struct packed {
        data_t     da;                           // decay factor from table
        lane_vec_t dbx;                          // dx * b per lane
        lane_vec_t c;
        lane_vec_t hprev;
        data_t     x;
        data_t     d;
        logic      first;
        logic      last;
    } s2_t;

    data_t     lut [LUT_DEPTH];                  // exp(-i/8) in q8.8
    data_t     delta_sum;
    data_t     delta;                            // clamped at zero
    data_t     a_abs;
    data_t     decay_prod;
    logic [15:0] idx_full;                       // unsaturated table index
    lut_idx_t  idx_c;
    lane_vec_t dbx_c;
    lane_vec_t hnext_c;
    lane_vec_t hc_c;
    s1_t       s1_q;
    s2_t       s2_q;
    logic      s1_valid;
    logic      s2_valid;

    initial $readmemh(LUT_FILE, lut);

    // ========================================================================
    // stage one, delta clamp and table index
    // ========================================================================
    always_comb begin
        delta_sum  = dec_i.tile.dt + dec_i.tile.dt_bias;   // wraps
        delta      = delta_sum[15] ? '0 : delta_sum;         // stands in for softplus
        a_abs      = dec_i.tile.a[15] ? -dec_i.tile.a : '0;  // positive a gives no decay
        decay_prod = q_mul(delta, a_abs);
        idx_full   = $unsigned(decay_prod) >> LUT_SHIFT;     // product read as unsigned
        if (idx_full > 16'(LUT_DEPTH - 1))
            idx_c = lut_idx_t'(LUT_DEPTH - 1);               // saturate at the last entry
        else
            idx_c = lut_idx_t'(idx_full);
    end

    // ========================================================================
    // stage two and three lane math
    // ========================================================================
    always_comb begin
        for (int n = 0; n < N_TILE; n++) begin
            dbx_c[n]   = q_mul(s1_q.dx, s1_q.b[n]);
            hnext_c[n] = q_mul(s2_q.da, s2_q.hprev[n]) + s2_q.dbx[n];
            hc_c[n]    = q_mul(hnext_c[n], s2_q.c[n]);
        end
    end

    // valid bits move as a shift register under adv
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else if (adv_i) begin
            s1_valid <= valid_i;
            s2_valid <= s1_valid;
            valid_o  <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            s1_q      <= '{idx_c, q_mul(delta, dec_i.tile.x), dec_i.tile.b, dec_i.tile.c,
                           dec_i.tile.hprev, dec_i.tile.x, dec_i.tile.d,
                           dec_i.first, dec_i.last};
            s2_q.da   <= lut[s1_q.idx];          // table read lands here
            s2_q.dbx  <= dbx_c;
            s2_q.c    <= s1_q.c;
            s2_q.hprev <= s1_q.hprev;
            s2_q.x    <= s1_q.x;
            s2_q.d    <= s1_q.d;
            s2_q.first <= s1_q.first;
            s2_q.last <= s1_q.last;
            res_o.hc  <= hc_c;
            res_o.xd  <= q_mul(s2_q.x, s2_q.d);
            res_o.first <= s2_q.first;
            res_o.last <= s2_q.last;
        end
    end

endmodule

//--- verilog/ssm_tile_decode.sv
// tiles must arrive in group order, a group is always TILES_PER_GROUP tiles with no gaps allowed in the count
`timescale 1ns/1ns

module ssm_tile_decode (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    adv_i,       // pipeline advance, low while output stalls
    input  logic                    valid_i,
    input  ssm_stage_pkg::tile_in_t tile_i,
    output logic                    valid_o,
    output ssm_stage_pkg::decoded_t dec_o
);
    import ssm_num_pkg::*;

    tile_idx_t tile_cnt;                         // position of the next tile in its group
    logic      accept;                           // tile taken on this edge
    logic      grp_first;
    logic      grp_last;

    // ========================================================================
    // group position
    // ========================================================================
    assign accept    = adv_i & valid_i;
    assign grp_first = (tile_cnt == '0);
    assign grp_last  = (tile_cnt == tile_idx_t'(TILES_PER_GROUP - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_cnt <= '0;
        end else if (accept) begin
            if (grp_last)
                tile_cnt <= '0;                  // wrap for the next group
            else
                tile_cnt <= tile_cnt + 1'b1;
        end
    end

    // ========================================================================
    // input register
    // ========================================================================

    // valid follows adv so a bubble also moves down the pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only, flags ride with the tile
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_o.tile  <= tile_i;
            dec_o.first <= grp_first;
            dec_o.last  <= grp_last;
        end
    end

endmodule

//--- verilog/ssm_stage_pkg.sv
// payload structs between pipeline stages, H and P dimensions fixed at 1
package ssm_stage_pkg;

    // ========================================================================
    // one input tile as it arrives on the stream
    // ========================================================================

    // x and D are only sampled from the first tile of a group
    typedef struct packed {
        ssm_num_pkg::data_t     dt;                  // raw step size
        ssm_num_pkg::data_t     dt_bias;             // step size bias
        ssm_num_pkg::data_t     a;                   // decay rate, negative for real decay
        ssm_num_pkg::data_t     x;                   // input sample
        ssm_num_pkg::data_t     d;                   // skip gain
        ssm_num_pkg::lane_vec_t b;                   // input projection per lane
        ssm_num_pkg::lane_vec_t c;                   // output projection per lane
        ssm_num_pkg::lane_vec_t hprev;               // previous state per lane
    } tile_in_t;                                     // 272 bits

    // ========================================================================
    // tile after decode, tagged with its position in the group
    // ========================================================================
    typedef struct packed {
        tile_in_t tile;
        logic     first;                             // first tile of a group
        logic     last;                              // closes the group
    } decoded_t;                                     // 274 bits

    // ========================================================================
    // state update output, one per tile
    // ========================================================================

    // xd is only meaningful on the first tile of the group
    typedef struct packed {
        ssm_num_pkg::lane_vec_t hc;                  // h_next * c per lane
        ssm_num_pkg::data_t     xd;                  // x * d
        logic                   first;
        logic                   last;
    } lane_result_t;                                 // 82 bits

endpackage

//--- verilog/ssm_num_pkg.sv
// signed q8.8 in 16 bits only, adds wrap, multiplies truncate toward minus infinity, table path relative to project root
package ssm_num_pkg;

    // ========================================================================
    // numeric format
    // ========================================================================
    localparam int FRAC_BITS = 8;                    // q8.8 fraction bits

    typedef logic signed [15:0] data_t;             // one q8.8 value

    // ========================================================================
    // sizes
    // ========================================================================
    localparam int N_TILE          = 4;              // lanes handled per tile
    localparam int N_TOTAL         = 16;             // lanes per group
    localparam int TILES_PER_GROUP = N_TOTAL / N_TILE;

    typedef data_t [N_TILE-1:0] lane_vec_t;         // lane 0 sits in the low word
    typedef logic [$clog2(TILES_PER_GROUP)-1:0] tile_idx_t;

    // ========================================================================
    // decay table
    // ========================================================================
    localparam int    LUT_DEPTH = 32;                // entries approximate exp(-i/8)
    localparam int    LUT_SHIFT = 5;                 // product >> 5 gives the index
    localparam string LUT_FILE  = "verilog/decay_lut.mem";

    typedef logic [$clog2(LUT_DEPTH)-1:0] lut_idx_t;

    // ========================================================================
    // arithmetic
    // ========================================================================

    // full 32 bit product, arithmetic shift back to q8.8, low 16 bits kept
    // overflow simply wraps, no saturation anywhere
    function automatic data_t q_mul(input data_t a, input data_t b);
        logic signed [31:0] prod;                    // full precision product
        prod = a * b;
        return data_t'(prod >>> FRAC_BITS);
    endfunction

endpackage
